// File: sources.f
rtl/bus_types_pkg.sv
rtl/mc_types_pkg.sv
rtl/generic_bus_if.sv
rtl/bus_ctrl_if.sv
rtl/bus_ctrl_regs.sv
rtl/hart_arbiter.sv
rtl/reservation_tracker.sv
rtl/memory_controller.sv
rtl/generic_nonpipeline.sv
rtl/multicore_bus_top.sv
tests/tb_multicore_bus.sv

// File: tests/testdata_bus.txt
# test op hart kind resv addr data be expect  (all hex but test)
# op 0 cfg write, 1 cfg read, 2 single, 3 pair of reads (data is hart 1 addr), 4 blocked read
1 2 0 2 0 00000010 11223344 f 00000000
1 2 0 1 0 00000010 00000000 f 11223344
1 2 1 2 0 00000020 a5a5c3c3 f 00000000
1 2 1 1 0 00000020 00000000 3 0000c3c3
1 2 0 1 0 00000020 00000000 c a5a50000
1 2 1 2 0 00000010 ffffffff 4 00000000
1 2 1 1 0 00000010 00000000 f 11ff3344
1 2 0 1 0 00000010 00000000 9 11000044
2 3 0 1 0 00000040 00000044 f 00000000
2 0 0 0 0 00000001 00000001 0 00000000
2 1 0 0 0 00000001 00000000 0 00000001
2 3 0 1 0 00000048 0000004c f 00000000
2 2 0 1 0 00000010 00000000 f 11ff3344
2 3 0 1 0 00000050 00000054 f 00000001
2 2 1 1 0 00000020 00000000 f a5a5c3c3
2 3 0 1 0 00000058 0000005c f 00000000
2 0 0 0 0 00000001 00000000 0 00000000
2 3 0 1 0 00000060 00000064 f 00000000
3 2 0 1 1 00000080 00000000 f c320df7a
3 2 0 2 1 00000080 cafef00d f 00000000
3 2 0 1 0 00000080 00000000 f cafef00d
3 2 0 2 1 00000080 12345678 f 00000001
3 2 0 1 0 00000080 00000000 f cafef00d
3 2 1 1 1 00000084 00000000 f c321de7b
3 2 1 2 1 00000084 0badbeef f 00000000
4 2 0 1 1 000000a0 00000000 f c328d772
4 2 1 2 0 000000a0 55aa55aa f 00000000
4 2 0 2 1 000000a0 99999999 f 00000001
4 2 0 1 0 000000a0 00000000 f 55aa55aa
4 2 0 1 1 000000c0 00000000 f c330cf6a
4 2 1 2 0 000000c4 77777777 f 00000000
4 2 0 2 1 000000c0 13579bdf f 00000000
4 2 0 1 0 000000c0 00000000 f 13579bdf
5 0 0 0 0 00000000 00000001 0 00000000
5 1 0 0 0 00000000 00000000 0 00000001
5 2 0 1 0 00000010 00000000 f 11ff3344
5 4 1 1 0 00000020 00000003 f a5a5c3c3
5 1 0 0 0 00000000 00000000 0 00000003
6 1 0 0 0 00000002 00000000 0 00000023
6 0 0 0 0 00000002 000000ff 0 00000000
6 1 0 0 0 00000002 00000000 0 00000023
6 1 0 0 0 00000001 00000000 0 00000000
6 0 0 0 0 00000000 00000002 0 00000000
6 1 0 0 0 00000000 00000000 0 00000002
6 0 0 0 0 00000000 00000003 0 00000000
6 1 0 0 0 00000000 00000000 0 00000003

// File: tests/tb_multicore_bus.sv
module tb_multicore_bus;
    timeunit 1ns;
    timeprecision 100ps;

    import bus_types_pkg::*;
    import mc_types_pkg::*;

    localparam int NUM_HARTS    = 2;
    localparam int DONE_TIMEOUT = 200;
    localparam int BLOCK_WINDOW = 50;

    logic                     CLK;
    logic                     rst_n;
    logic [NUM_HARTS-1:0]     hart_ren;
    logic [NUM_HARTS-1:0]     hart_wen;
    logic [NUM_HARTS-1:0]     hart_resv;
    addr_t    [NUM_HARTS-1:0] hart_addr;
    word_t    [NUM_HARTS-1:0] hart_wdata;
    byte_en_t [NUM_HARTS-1:0] hart_byte_en;
    logic [NUM_HARTS-1:0]     hart_busy;
    word_t    [NUM_HARTS-1:0] hart_rdata;
    logic                     bus_ren;
    logic                     bus_wen;
    addr_t                    bus_addr;
    word_t                    bus_wdata;
    byte_en_t                 bus_byte_en;
    word_t                    bus_rdata;
    logic                     bus_busy;
    logic                     cfg_we;
    cfg_addr_t                cfg_addr;
    word_t                    cfg_wdata;
    word_t                    cfg_rdata;

    // External memory model.
    word_t       mem [256];
    logic [31:0] lfsr_state;
    logic        mem_active;
    int          mem_wait;

    int cur_test;
    int line_no;
    int steps;
    int test_errors;
    int errors;
    int tests_run;
    int tests_failed;
    bit timed_out;

    multicore_bus_top #(
        .NUM_HARTS(NUM_HARTS)
    ) u_multicore_bus_top (
        .CLK(CLK),
        .rst_n(rst_n),
        .hart_ren(hart_ren),
        .hart_wen(hart_wen),
        .hart_resv(hart_resv),
        .hart_addr(hart_addr),
        .hart_wdata(hart_wdata),
        .hart_byte_en(hart_byte_en),
        .hart_busy(hart_busy),
        .hart_rdata(hart_rdata),
        .bus_ren(bus_ren),
        .bus_wen(bus_wen),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_byte_en(bus_byte_en),
        .bus_rdata(bus_rdata),
        .bus_busy(bus_busy),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic word_t fill_word(input logic [7:0] idx);
        return {8'hc3, idx, ~idx, idx ^ 8'h5a};
    endfunction

    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w,
                                          input byte_en_t be);
        word_t w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return w;
    endfunction

    // Slave answers after 0 to 3 wait cycles taken from two random bits.
    always @(negedge CLK) begin
        if (!rst_n) begin
            bus_busy   = 1'b1;
            mem_active = 1'b0;
        end else begin
            if ((bus_ren || bus_wen) && !mem_active) begin
                mem_active = 1'b1;
                lfsr_state = lfsr_step(lfsr_state);
                mem_wait   = lfsr_state[0];
                lfsr_state = lfsr_step(lfsr_state);
                mem_wait   = 2 * mem_wait + lfsr_state[0];
            end
            if (mem_active && mem_wait == 0) begin
                bus_busy   = 1'b0;
                bus_rdata  = mem[bus_addr[9:2]];
                mem_active = 1'b0;
                if (bus_wen) begin
                    mem[bus_addr[9:2]] = merge_lanes(mem[bus_addr[9:2]], bus_wdata, bus_byte_en);
                end
            end else if (mem_active) begin
                bus_busy = 1'b1;
                mem_wait--;
            end else begin
                bus_busy = 1'b1;
            end
        end
    end

    task automatic report_value(input string name, input word_t expected, input word_t actual);
        $display("error: test %0d line %0d: %s expected %h got %h",
                 cur_test, line_no, name, expected, actual);
        test_errors++;
    endtask

    task automatic report_text(input string msg);
        $display("test %0d line %0d: %s", cur_test, line_no, msg);
        test_errors++;
    endtask

    task automatic close_test();
        if (cur_test > 0) begin
            tests_run++;
            if (test_errors != 0) begin
                tests_failed++;
            end
            $display("test %0d: %s, %0d steps, %0d errors", cur_test,
                     (test_errors == 0) ? "passed" : "failed", steps, test_errors);
            errors += test_errors;
        end
        test_errors = 0;
        steps       = 0;
    endtask

    task automatic drive_request(input int h, input int kind, input int resv, input addr_t a,
                                 input word_t d, input byte_en_t be);
        hart_ren[h]     = (kind == 1);
        hart_wen[h]     = (kind == 2);
        hart_resv[h]    = (resv != 0);
        hart_addr[h]    = a;
        hart_wdata[h]   = d;
        hart_byte_en[h] = be;
    endtask

    task automatic release_request(input int h);
        hart_ren[h]  = 1'b0;
        hart_wen[h]  = 1'b0;
        hart_resv[h] = 1'b0;
    endtask

    task automatic wait_done(input int h, input int limit, output bit done);
        done = 1'b0;
        for (int n = 0; n < limit && !done; n++) begin
            @(negedge CLK);
            done = !hart_busy[h];
        end
    endtask

    task automatic cfg_write(input cfg_addr_t a, input word_t d);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge CLK);
        cfg_we = 1'b0;
    endtask

    task automatic cfg_read(input cfg_addr_t a, input word_t expected);
        cfg_addr = a;
        @(negedge CLK);
        if (cfg_rdata !== expected) begin
            report_value("cfg_rdata", expected, cfg_rdata);
        end
    endtask

    task automatic run_single(input int h, input int kind, input int resv, input addr_t a,
                              input word_t d, input byte_en_t be, input word_t expected);
        bit done;
        drive_request(h, kind, resv, a, d, be);
        wait_done(h, DONE_TIMEOUT, done);
        release_request(h);
        if (!done) begin
            report_text($sformatf("timeout, hart %0d never completed its request", h));
            timed_out = 1'b1;
        end else if (hart_rdata[h] !== expected) begin
            report_value($sformatf("hart_rdata[%0d]", h), expected, hart_rdata[h]);
        end
        @(negedge CLK);
        // Completion lasts a single cycle.
        if (done && !hart_busy[h]) begin
            report_text($sformatf("hart %0d busy stayed low for more than one cycle", h));
        end
    endtask

    // Both harts read in the same cycle.
    task automatic run_pair(input addr_t a0, input addr_t a1, input int expect_first);
        word_t                exp_data [NUM_HARTS];
        logic [NUM_HARTS-1:0] pending;
        int                   first;
        exp_data[0] = mem[a0[9:2]];
        exp_data[1] = mem[a1[9:2]];
        drive_request(0, 1, 0, a0, '0, 4'hf);
        drive_request(1, 1, 0, a1, '0, 4'hf);
        pending = '1;
        first   = -1;
        for (int n = 0; n < DONE_TIMEOUT && pending != 0; n++) begin
            @(negedge CLK);
            for (int h = 0; h < NUM_HARTS; h++) begin
                if (pending[h] && !hart_busy[h]) begin
                    if (first < 0) begin
                        first = h;
                    end
                    if (hart_rdata[h] !== exp_data[h]) begin
                        report_value($sformatf("hart_rdata[%0d]", h), exp_data[h], hart_rdata[h]);
                    end
                    release_request(h);
                    pending[h] = 1'b0;
                end
            end
        end
        if (pending != 0) begin
            report_text("timeout, paired requests did not both complete");
            timed_out = 1'b1;
        end else if (first != expect_first) begin
            report_value("first hart_busy low", word_t'(expect_first), word_t'(first));
        end
        @(negedge CLK);
    endtask

    // Request from a disabled hart, then enable it with the given mask.
    task automatic run_blocked(input int h, input addr_t a, input word_t mask,
                               input byte_en_t be, input word_t expected);
        bit done;
        drive_request(h, 1, 0, a, '0, be);
        wait_done(h, BLOCK_WINDOW, done);
        if (done) begin
            release_request(h);
            report_text($sformatf("hart %0d completed a request while disabled", h));
        end else begin
            cfg_write(CFG_ENABLE, mask);
            wait_done(h, DONE_TIMEOUT, done);
            release_request(h);
            if (!done) begin
                report_text($sformatf("timeout, hart %0d never completed after enable", h));
                timed_out = 1'b1;
            end else if (hart_rdata[h] !== expected) begin
                report_value($sformatf("hart_rdata[%0d]", h), expected, hart_rdata[h]);
            end
        end
        @(negedge CLK);
    endtask

    initial begin
        int       fd;
        string    line;
        int       n_fields;
        int       test_id;
        int       op;
        int       h;
        int       kind;
        int       resv;
        addr_t    a;
        word_t    d;
        int       be;
        word_t    expected;
        rst_n        = 1'b0;
        hart_ren     = '0;
        hart_wen     = '0;
        hart_resv    = '0;
        hart_addr    = '0;
        hart_wdata   = '0;
        hart_byte_en = '0;
        bus_rdata    = '0;
        bus_busy     = 1'b1;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        lfsr_state   = 32'h8ef7_281c;
        mem_active   = 1'b0;
        mem_wait     = 0;
        cur_test     = 0;
        line_no      = 0;
        steps        = 0;
        test_errors  = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
        end
        repeat (16) @(negedge CLK);
        rst_n = 1'b1;
        @(negedge CLK);

        fd = $fopen("tests/testdata_bus.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/testdata_bus.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                line_no++;
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n_fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h",
                                   test_id, op, h, kind, resv, a, d, be, expected);
                if (n_fields != 9) begin
                    $display("line %0d: could not read the stimulus fields", line_no);
                    errors++;
                    continue;
                end
                if (test_id != cur_test) begin
                    close_test();
                    cur_test = test_id;
                end
                steps++;
                case (op)
                    0: cfg_write(cfg_addr_t'(a), d);
                    1: cfg_read(cfg_addr_t'(a), expected);
                    2: run_single(h, kind, resv, a, d, byte_en_t'(be), expected);
                    3: run_pair(a, d, int'(expected));
                    4: run_blocked(h, a, d, byte_en_t'(be), expected);
                    default: report_text("unknown operation code");
                endcase
            end
            close_test();
            $fclose(fd);
        end

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: rtl/multicore_bus_top.sv
module multicore_bus_top #(
    parameter int NUM_HARTS = 2
) (
    input  logic                                    CLK,
    input  logic                                    rst_n,
    input  logic [NUM_HARTS-1:0]                    hart_ren,
    input  logic [NUM_HARTS-1:0]                    hart_wen,
    input  logic [NUM_HARTS-1:0]                    hart_resv,
    input  bus_types_pkg::addr_t    [NUM_HARTS-1:0] hart_addr,
    input  bus_types_pkg::word_t    [NUM_HARTS-1:0] hart_wdata,
    input  bus_types_pkg::byte_en_t [NUM_HARTS-1:0] hart_byte_en,
    output logic [NUM_HARTS-1:0]                    hart_busy,
    output bus_types_pkg::word_t    [NUM_HARTS-1:0] hart_rdata,
    output logic                                    bus_ren,
    output logic                                    bus_wen,
    output bus_types_pkg::addr_t                    bus_addr,
    output bus_types_pkg::word_t                    bus_wdata,
    output bus_types_pkg::byte_en_t                 bus_byte_en,
    input  bus_types_pkg::word_t                    bus_rdata,
    input  logic                                    bus_busy,
    input  logic                                    cfg_we,
    input  mc_types_pkg::cfg_addr_t                 cfg_addr,
    input  bus_types_pkg::word_t                    cfg_wdata,
    output bus_types_pkg::word_t                    cfg_rdata
);
    import mc_types_pkg::*;

    logic [$clog2(NUM_HARTS)-1:0] grant_idx;
    logic                         grant_valid;
    logic                         advance;
    logic                         xfer_done;
    logic [NUM_HARTS-1:0]         hart_enable;
    arb_mode_t                    arb_mode;

    generic_bus_if pipeline_trans_if ();
    bus_ctrl_if #(.NUM_HARTS(NUM_HARTS)) bcif ();

    bus_ctrl_regs #(
        .NUM_HARTS(NUM_HARTS)
    ) u_regs (
        .CLK(CLK),
        .rst_n(rst_n),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .cfg_rdata(cfg_rdata),
        .xfer_done(xfer_done),
        .hart_enable(hart_enable),
        .arb_mode(arb_mode)
    );

    // Requests of either kind compete.
    hart_arbiter #(
        .NUM_HARTS(NUM_HARTS)
    ) u_arb (
        .CLK(CLK),
        .rst_n(rst_n),
        .req(hart_ren | hart_wen),
        .hart_enable(hart_enable),
        .arb_mode(arb_mode),
        .advance(advance),
        .grant_idx(grant_idx),
        .grant_valid(grant_valid)
    );

    reservation_tracker #(
        .NUM_HARTS(NUM_HARTS)
    ) u_resv (
        .CLK(CLK),
        .rst_n(rst_n),
        .bcif(bcif)
    );

    memory_controller #(
        .NUM_HARTS(NUM_HARTS)
    ) u_mc (
        .CLK(CLK),
        .rst_n(rst_n),
        .hart_ren(hart_ren),
        .hart_wen(hart_wen),
        .hart_resv(hart_resv),
        .hart_addr(hart_addr),
        .hart_wdata(hart_wdata),
        .hart_byte_en(hart_byte_en),
        .hart_busy(hart_busy),
        .hart_rdata(hart_rdata),
        .out_gen_bus_if(pipeline_trans_if),
        .bcif(bcif),
        .grant_idx(grant_idx),
        .grant_valid(grant_valid),
        .advance(advance),
        .xfer_done(xfer_done)
    );

    generic_nonpipeline u_bt (
        .CLK(CLK),
        .rst_n(rst_n),
        .pipeline_trans_if(pipeline_trans_if),
        .bus_ren(bus_ren),
        .bus_wen(bus_wen),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_byte_en(bus_byte_en),
        .bus_rdata(bus_rdata),
        .bus_busy(bus_busy)
    );

endmodule

// File: rtl/generic_nonpipeline.sv
module generic_nonpipeline (
    input  logic                     CLK,
    input  logic                     rst_n,
    generic_bus_if.translator        pipeline_trans_if,
    output logic                     bus_ren,
    output logic                     bus_wen,
    output bus_types_pkg::addr_t     bus_addr,
    output bus_types_pkg::word_t     bus_wdata,
    output bus_types_pkg::byte_en_t  bus_byte_en,
    input  bus_types_pkg::word_t     bus_rdata,
    input  logic                     bus_busy
);
    import bus_types_pkg::*;

    logic active;

    assign active = bus_ren | bus_wen;

    // Capture when idle, drop after the slave finishes.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            bus_ren <= 1'b0;
            bus_wen <= 1'b0;
        end else if (active) begin
            if (!bus_busy) begin
                bus_ren <= 1'b0;
                bus_wen <= 1'b0;
            end
        end else begin
            bus_ren <= pipeline_trans_if.ren;
            bus_wen <= pipeline_trans_if.wen;
        end
    end

    always_ff @(posedge CLK) begin
        if (!active) begin
            bus_addr    <= pipeline_trans_if.addr;
            bus_wdata   <= pipeline_trans_if.wdata;
            bus_byte_en <= pipeline_trans_if.byte_en;
        end
    end

    assign pipeline_trans_if.busy = !(active && !bus_busy);

    // Disabled lanes read as zero.
    always_comb begin
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            pipeline_trans_if.rdata[8*i +: 8] = bus_byte_en[i] ? bus_rdata[8*i +: 8] : 8'h00;
        end
    end

endmodule

// File: rtl/memory_controller.sv
module memory_controller #(
    parameter int NUM_HARTS = 2
) (
    input  logic                                      CLK,
    input  logic                                      rst_n,
    input  logic [NUM_HARTS-1:0]                      hart_ren,
    input  logic [NUM_HARTS-1:0]                      hart_wen,
    input  logic [NUM_HARTS-1:0]                      hart_resv,
    input  bus_types_pkg::addr_t    [NUM_HARTS-1:0]   hart_addr,
    input  bus_types_pkg::word_t    [NUM_HARTS-1:0]   hart_wdata,
    input  bus_types_pkg::byte_en_t [NUM_HARTS-1:0]   hart_byte_en,
    output logic [NUM_HARTS-1:0]                      hart_busy,
    output bus_types_pkg::word_t    [NUM_HARTS-1:0]   hart_rdata,
    generic_bus_if.controller                         out_gen_bus_if,
    bus_ctrl_if.controller                            bcif,
    input  logic [$clog2(NUM_HARTS)-1:0]              grant_idx,
    input  logic                                      grant_valid,
    output logic                                      advance,
    output logic                                      xfer_done
);
    import bus_types_pkg::*;
    import mc_types_pkg::*;

    localparam int IDX_W = $clog2(NUM_HARTS);

    mc_state_t        state;
    logic [IDX_W-1:0] sel_idx;
    logic             sc_req;
    logic             sc_fail;
    logic             req_ren;
    logic             req_wen;
    logic             req_resv;
    addr_t            req_addr;
    word_t            req_wdata;
    byte_en_t         req_byte_en;
    word_t            resp_rdata;

    // Store-conditional from the selected hart.
    assign sc_req = hart_wen[sel_idx] && hart_resv[sel_idx];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state   <= MC_IDLE;
            sel_idx <= '0;
            sc_fail <= 1'b0;
        end else begin
            case (state)
                MC_IDLE: begin
                    if (grant_valid) begin
                        sel_idx <= grant_idx;
                        state   <= MC_GRANT;
                    end
                end
                MC_GRANT: begin
                    sc_fail <= sc_req && !bcif.sc_ok;
                    // A lost reservation never reaches the bus.
                    state   <= (sc_req && !bcif.sc_ok) ? MC_DONE : MC_ACCESS;
                end
                MC_ACCESS: begin
                    if (!out_gen_bus_if.busy) begin
                        state <= MC_DONE;
                    end
                end
                default: state <= MC_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == MC_GRANT) begin
            req_ren     <= hart_ren[sel_idx];
            req_wen     <= hart_wen[sel_idx];
            req_resv    <= hart_resv[sel_idx];
            req_addr    <= hart_addr[sel_idx];
            req_wdata   <= hart_wdata[sel_idx];
            req_byte_en <= hart_byte_en[sel_idx];
        end
        if (state == MC_GRANT && sc_req && !bcif.sc_ok) begin
            resp_rdata <= word_t'(1);
        end else if (state == MC_ACCESS && !out_gen_bus_if.busy) begin
            resp_rdata <= req_ren ? out_gen_bus_if.rdata : '0;
        end
    end

    assign out_gen_bus_if.ren     = (state == MC_ACCESS) && req_ren;
    assign out_gen_bus_if.wen     = (state == MC_ACCESS) && req_wen;
    assign out_gen_bus_if.addr    = req_addr;
    assign out_gen_bus_if.wdata   = req_wdata;
    assign out_gen_bus_if.byte_en = req_byte_en;

    // Check uses live hart fields while still in grant.
    assign bcif.hart_idx   = sel_idx;
    assign bcif.resv_addr  = (state == MC_GRANT) ? hart_addr[sel_idx] : req_addr;
    assign bcif.sc_check   = (state == MC_GRANT) && sc_req;
    assign bcif.resv_set   = (state == MC_DONE) && req_ren && req_resv;
    assign bcif.store      = (state == MC_DONE) && req_wen && !sc_fail;
    assign bcif.store_addr = req_addr;

    always_comb begin
        for (int i = 0; i < NUM_HARTS; i++) begin
            hart_busy[i]  = !(state == MC_DONE && sel_idx == IDX_W'(i));
            hart_rdata[i] = resp_rdata;
        end
    end

    assign advance   = (state == MC_DONE);
    assign xfer_done = (state == MC_DONE) && !sc_fail;

endmodule

// File: rtl/reservation_tracker.sv
module reservation_tracker #(
    parameter int NUM_HARTS = 2
) (
    input logic        CLK,
    input logic        rst_n,
    bus_ctrl_if.tracker bcif
);
    import bus_types_pkg::*;

    localparam int AW = $bits(addr_t);

    logic [NUM_HARTS-1:0] resv_valid;
    addr_t                resv_word [NUM_HARTS];

    // Valid bits.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            resv_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_HARTS; i++) begin
                if (bcif.store && (bcif.hart_idx == i ||
                        resv_word[i][AW-1:2] == bcif.store_addr[AW-1:2])) begin
                    // Any matching store kills it, and so does our own store.
                    resv_valid[i] <= 1'b0;
                end else if (bcif.resv_set && bcif.hart_idx == i) begin
                    resv_valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_HARTS; i++) begin
            if (bcif.resv_set && bcif.hart_idx == i) begin
                resv_word[i] <= bcif.resv_addr;
            end
        end
    end

    // Word compare only, byte offset ignored.
    assign bcif.sc_ok = bcif.sc_check && resv_valid[bcif.hart_idx] &&
                        resv_word[bcif.hart_idx][AW-1:2] == bcif.resv_addr[AW-1:2];

endmodule

// File: rtl/hart_arbiter.sv
module hart_arbiter #(
    parameter int NUM_HARTS = 2
) (
    input  logic                         CLK,
    input  logic                         rst_n,
    input  logic [NUM_HARTS-1:0]         req,
    input  logic [NUM_HARTS-1:0]         hart_enable,
    input  mc_types_pkg::arb_mode_t      arb_mode,
    input  logic                         advance,
    output logic [$clog2(NUM_HARTS)-1:0] grant_idx,
    output logic                         grant_valid
);
    import mc_types_pkg::*;

    localparam int IDX_W = $clog2(NUM_HARTS);

    logic [NUM_HARTS-1:0] req_masked;
    logic [IDX_W-1:0]     rr_ptr;
    logic [IDX_W-1:0]     held_idx;
    logic [IDX_W-1:0]     pick_idx;
    logic                 pick_valid;
    logic                 locked;

    assign req_masked = req & hart_enable;

    // Search starts at the pointer in round-robin mode, at 0 otherwise.
    always_comb begin
        int idx;
        pick_idx   = '0;
        pick_valid = 1'b0;
        for (int k = 0; k < NUM_HARTS; k++) begin
            if (arb_mode == ARB_RR) begin
                idx = (int'(rr_ptr) + k) % NUM_HARTS;
            end else begin
                idx = k;
            end
            if (!pick_valid && req_masked[idx]) begin
                pick_valid = 1'b1;
                pick_idx   = IDX_W'(idx);
            end
        end
    end

    // Grant stays fixed until the controller finishes with it.
    assign grant_idx   = locked ? held_idx : pick_idx;
    assign grant_valid = locked | pick_valid;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            locked   <= 1'b0;
            held_idx <= '0;
            rr_ptr   <= '0;
        end else if (advance) begin
            locked <= 1'b0;
            if (arb_mode == ARB_RR) begin
                rr_ptr <= (held_idx == IDX_W'(NUM_HARTS - 1)) ? '0 : held_idx + 1'b1;
            end
        end else if (!locked && pick_valid) begin
            locked   <= 1'b1;
            held_idx <= pick_idx;
        end
    end

endmodule

// File: rtl/bus_ctrl_regs.sv
module bus_ctrl_regs #(
    parameter int NUM_HARTS = 2
) (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    cfg_we,
    input  mc_types_pkg::cfg_addr_t cfg_addr,
    input  bus_types_pkg::word_t    cfg_wdata,
    output bus_types_pkg::word_t    cfg_rdata,
    input  logic                    xfer_done,
    output logic [NUM_HARTS-1:0]    hart_enable,
    output mc_types_pkg::arb_mode_t arb_mode
);
    import bus_types_pkg::*;
    import mc_types_pkg::*;

    word_t xfer_count;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            hart_enable <= '1;
            arb_mode    <= ARB_FIXED;
            xfer_count  <= '0;
        end else begin
            if (cfg_we && cfg_addr == CFG_ENABLE) begin
                hart_enable <= cfg_wdata[NUM_HARTS-1:0];
            end
            if (cfg_we && cfg_addr == CFG_MODE) begin
                arb_mode <= arb_mode_t'(cfg_wdata[0]);
            end
            // Only transfers that reached the bus.
            if (xfer_done) begin
                xfer_count <= xfer_count + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_ENABLE: cfg_rdata = word_t'(hart_enable);
            CFG_MODE:   cfg_rdata = word_t'(arb_mode);
            CFG_COUNT:  cfg_rdata = xfer_count;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

// File: rtl/bus_ctrl_if.sv
interface bus_ctrl_if #(
    parameter int NUM_HARTS = 2
);
    import bus_types_pkg::*;

    // Hart currently owned by the controller.
    logic [$clog2(NUM_HARTS)-1:0] hart_idx;
    // Address for reservation set and check.
    addr_t                        resv_addr;
    logic                         resv_set;
    logic                         sc_check;
    // Completed bus store, snooped by every hart entry.
    logic                         store;
    addr_t                        store_addr;
    logic                         sc_ok;

    modport controller (
        output hart_idx, resv_addr, resv_set, sc_check, store, store_addr,
        input  sc_ok
    );

    modport tracker (
        input  hart_idx, resv_addr, resv_set, sc_check, store, store_addr,
        output sc_ok
    );

endinterface

// File: rtl/generic_bus_if.sv
interface generic_bus_if;
    import bus_types_pkg::*;

    logic     ren;
    logic     wen;
    addr_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
    word_t    rdata;
    logic     busy;

    // Request side, held until busy drops.
    modport controller (
        output ren, wen, addr, wdata, byte_en,
        input  rdata, busy
    );

    modport translator (
        input  ren, wen, addr, wdata, byte_en,
        output rdata, busy
    );

endinterface

// File: rtl/mc_types_pkg.sv
package mc_types_pkg;

    // Memory controller states.
    typedef enum logic [1:0] {
        MC_IDLE,
        MC_GRANT,
        MC_ACCESS,
        MC_DONE
    } mc_state_t;

    typedef enum logic {
        ARB_FIXED,
        ARB_RR
    } arb_mode_t;

    // Configuration register index.
    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t CFG_ENABLE = 2'd0;
    localparam cfg_addr_t CFG_MODE   = 2'd1;
    // Read only.
    localparam cfg_addr_t CFG_COUNT  = 2'd2;

endpackage

// File: rtl/bus_types_pkg.sv
package bus_types_pkg;

    // Byte address on the shared bus.
    typedef logic [31:0] addr_t;

    // Data word carried by reads and writes.
    typedef logic [31:0] word_t;

    // One enable per byte lane of word_t.
    typedef logic [3:0] byte_en_t;

endpackage
